//--- common/sd_defines.svh
`ifndef SD_DEFINES_SVH
`define SD_DEFINES_SVH

// data bytes in one read block
`define SD_BLOCK_BYTES 512

// 0xFF filler bytes ahead of every start token
`define SD_GAP_BYTES 4

// start block token for single and multi-block reads
`define SD_DATA_TOKEN 8'hFE

// stand-in for the data CRC16, sent high byte first
`define SD_CRC_FILL 16'h1122

// start + transmission + index + argument + crc7 + end
`define SD_CMD_BITS 48

// flops between the pads and the clk domain
`define SD_SYNC_STAGES 2

`endif

//--- common/sd_proto_pkg.sv
`default_nettype none

package sd_proto_pkg;

    // command index, six bits after the transmission bit
    typedef logic [5:0] cmd_idx_t;

    // command argument, sent MSB first
    typedef logic [31:0] cmd_arg_t;

    // R1 status byte
    // bit 0 in idle state, bit 2 illegal command, bit 7 always zero
    typedef logic [7:0] r1_t;

    // full response slot, R1 on top and four trailing bytes below
    // trailing bytes read 0xFF when the command has no R3/R7 payload
    typedef logic [39:0] resp_t;

    // card state as seen from the host
    typedef enum logic [1:0] {
        st_unknown,     // before CMD0
        st_idle,        // after CMD0, waiting for ACMD41
        st_ready,       // initialized
        st_data         // multi-block read running
    } card_state_t;

endpackage

`default_nettype wire

//--- common/sd_link_pkg.sv
`default_nettype none

package sd_link_pkg;

    // command frame parser
    typedef enum logic [1:0] {
        fr_idle,        // hunting for start and transmission bits
        fr_shift,       // collecting the rest of the frame
        fr_dummy        // waiting out the byte before the response
    } frame_state_t;

    // bit position inside a byte
    typedef logic [2:0] bit_cnt_t;

    // byte position in one block cycle: gap, token, data, crc
    typedef logic [9:0] byte_off_t;

    // per-block tag mixed into the data pattern
    typedef logic [7:0] block_tag_t;

endpackage

`default_nettype wire

//--- design/sd_spi_frontend.sv
`timescale 1ns/1ps
`default_nettype none

`include "sd_defines.svh"

module sd_spi_frontend (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic sclk,
    input  wire logic cs_n,
    input  wire logic mosi,
    output logic      sclk_rise,
    output logic      sclk_fall,
    output logic      mosi_bit,
    output logic      cs_active
);

    logic [`SD_SYNC_STAGES-1:0] sclk_sync;
    logic [`SD_SYNC_STAGES-1:0] cs_sync;
    logic [`SD_SYNC_STAGES-1:0] mosi_sync;
    logic                       sclk_s;     // synchronized sclk
    logic                       sclk_q;     // sclk_s one clk back
    logic                       sel;        // chip select, active level

    assign sclk_s = sclk_sync[`SD_SYNC_STAGES-1];
    assign sel    = ~cs_sync[`SD_SYNC_STAGES-1];

    // edges are registered so mosi_bit lines up with sclk_rise
    always_ff @(posedge clk) begin
        if (rst) begin
            sclk_sync <= '0;
            cs_sync   <= '1;
            mosi_sync <= '1;
            sclk_q    <= 1'b0;
            sclk_rise <= 1'b0;
            sclk_fall <= 1'b0;
            mosi_bit  <= 1'b1;
            cs_active <= 1'b0;
        end else begin
            sclk_sync <= {sclk_sync[`SD_SYNC_STAGES-2:0], sclk};
            cs_sync   <= {cs_sync[`SD_SYNC_STAGES-2:0], cs_n};
            mosi_sync <= {mosi_sync[`SD_SYNC_STAGES-2:0], mosi};
            sclk_q    <= sclk_s;
            sclk_rise <= sel & sclk_s & ~sclk_q;
            sclk_fall <= sel & ~sclk_s & sclk_q;
            mosi_bit  <= mosi_sync[`SD_SYNC_STAGES-1];
            cs_active <= sel;
        end
    end

    a_one_edge: assert property (@(posedge clk) disable iff (rst) !(sclk_rise && sclk_fall))
        else $error("sclk rise and fall in the same clk");

endmodule

`default_nettype wire

//--- sd_cmd/sd_cmd_receiver.sv
`timescale 1ns/1ps
`default_nettype none

`include "sd_defines.svh"

module sd_cmd_receiver (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             sclk_rise,
    input  wire logic             sclk_fall,
    input  wire logic             mosi_bit,
    input  wire logic             cs_active,
    output logic                  cmd_valid,
    output sd_proto_pkg::cmd_idx_t cmd_idx,
    output sd_proto_pkg::cmd_arg_t cmd_arg,
    output logic                  resp_slot
);

    import sd_link_pkg::*;

    localparam logic [5:0] last_bit = 6'(`SD_CMD_BITS - 1);
    localparam int         sr_top   = `SD_CMD_BITS - 4;   // holds frame bits 2..46

    frame_state_t    state;
    logic            start_seen;   // a 0 went past while idle
    logic [5:0]      bit_no;       // frame bits taken so far
    logic [sr_top:0] frame_sr;
    bit_cnt_t        dummy_cnt;
    logic            dummy_done;   // all eight dummy bits clocked in
    logic            frame_end;

    assign frame_end = (state == fr_shift) && sclk_rise && (bit_no == last_bit);

    // response goes out from the byte boundary that closes the dummy byte
    assign resp_slot = (state == fr_dummy) && dummy_done && sclk_fall;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= fr_idle;
            start_seen <= 1'b0;
            bit_no     <= '0;
            dummy_cnt  <= '0;
            dummy_done <= 1'b0;
            cmd_valid  <= 1'b0;
        end else begin
            cmd_valid <= frame_end;
            if (!cs_active) begin
                state      <= fr_idle;      // cs high drops a partial frame
                start_seen <= 1'b0;
            end else begin
                case (state)
                    fr_idle: begin
                        if (sclk_rise) begin
                            if (!mosi_bit) begin
                                start_seen <= 1'b1;
                            end else if (start_seen) begin
                                state      <= fr_shift;   // start and transmission bits seen
                                bit_no     <= 6'd2;
                                start_seen <= 1'b0;
                            end
                        end
                    end
                    fr_shift: begin
                        if (sclk_rise) begin
                            if (bit_no == last_bit) begin
                                state      <= fr_dummy;
                                dummy_cnt  <= '0;
                                dummy_done <= 1'b0;
                            end else begin
                                bit_no <= bit_no + 6'd1;
                            end
                        end
                    end
                    fr_dummy: begin
                        if (sclk_rise) begin
                            dummy_cnt <= dummy_cnt + 3'd1;
                            if (dummy_cnt == 3'd7) begin
                                dummy_done <= 1'b1;
                            end
                        end
                        if (resp_slot) begin
                            state <= fr_idle;
                        end
                    end
                    default: state <= fr_idle;
                endcase
            end
        end
    end

    // crc7 and end bit shift through but are never checked
    always_ff @(posedge clk) begin
        if (state == fr_shift && sclk_rise) begin
            frame_sr <= {frame_sr[sr_top-1:0], mosi_bit};
        end
        if (frame_end) begin
            cmd_idx <= frame_sr[sr_top -: 6];
            cmd_arg <= frame_sr[sr_top-6 -: 32];
        end
    end

    a_valid_not_slot: assert property (@(posedge clk) disable iff (rst)
        !(cmd_valid && resp_slot))
        else $error("command strobe overlaps response slot");

endmodule

`default_nettype wire

//--- sd_cmd/sd_card_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module sd_card_fsm (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire logic                    cmd_valid,
    input  wire sd_proto_pkg::cmd_idx_t  cmd_idx,
    input  wire sd_proto_pkg::cmd_arg_t  cmd_arg,
    output sd_proto_pkg::resp_t          resp,
    output sd_proto_pkg::card_state_t    card_state,
    output logic                         read_start,
    output logic                         read_stop,
    output sd_link_pkg::block_tag_t      start_tag
);

    import sd_proto_pkg::*;

    card_state_t next_state;
    r1_t         next_r1;
    cmd_arg_t    next_tail;     // bytes after R1
    logic        illegal;
    logic        app_cmd;       // last command was CMD55
    logic        hcs;           // host capacity bit from ACMD41
    logic        take_start;
    logic        take_stop;
    logic        set_app;
    logic        set_hcs;

    always_comb begin
        next_state = card_state;
        next_tail  = 32'hFFFF_FFFF;
        illegal    = 1'b0;
        take_start = 1'b0;
        take_stop  = 1'b0;
        set_app    = 1'b0;
        set_hcs    = 1'b0;
        if (card_state == st_unknown && cmd_idx != 6'd0) begin
            illegal = 1'b1;     // nothing but CMD0 before reset
        end else begin
            case (cmd_idx)
                6'd0: begin
                    next_state = st_idle;
                    take_stop  = (card_state == st_data);   // reset ends a running read
                end
                6'd8: next_tail = {20'h0_0000, cmd_arg[11:0]};   // voltage + check pattern
                6'd12: begin
                    if (card_state == st_data) begin
                        next_state = st_ready;
                        take_stop  = 1'b1;
                    end else begin
                        illegal = 1'b1;
                    end
                end
                6'd18: begin
                    if (card_state == st_ready) begin
                        next_state = st_data;
                        take_start = 1'b1;
                    end else begin
                        illegal = 1'b1;
                    end
                end
                6'd41: begin
                    if (app_cmd && card_state != st_data) begin
                        next_state = st_ready;
                        set_hcs    = 1'b1;
                    end else begin
                        illegal = 1'b1;
                    end
                end
                6'd55: set_app = 1'b1;
                6'd58: next_tail = {1'b1, hcs, 30'h00FF_8000};   // OCR, power up done
                default: illegal = 1'b1;
            endcase
        end
        next_r1 = {5'b0_0000, illegal, 1'b0, next_state == st_idle};
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            card_state <= st_unknown;
            resp       <= '1;
            app_cmd    <= 1'b0;
            hcs        <= 1'b0;
            read_start <= 1'b0;
            read_stop  <= 1'b0;
        end else begin
            read_start <= 1'b0;
            read_stop  <= 1'b0;
            if (cmd_valid) begin
                card_state <= next_state;
                resp       <= {next_r1, next_tail};
                app_cmd    <= set_app;      // lasts for one command only
                read_start <= take_start;
                read_stop  <= take_stop;
                if (set_hcs) begin
                    hcs <= cmd_arg[30];
                end
            end
        end
    end

    // argument holds until the next frame, long past read_start
    assign start_tag = cmd_arg[7:0];

endmodule

`default_nettype wire

//--- sd_read/sd_read_counter.sv
`timescale 1ns/1ps
`default_nettype none

`include "sd_defines.svh"

module sd_read_counter (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire logic                    sclk_fall,
    input  wire logic                    read_start,
    input  wire logic                    read_stop,
    input  wire sd_link_pkg::block_tag_t start_tag,
    output logic                         stream_on,
    output sd_link_pkg::byte_off_t       byte_off,
    output sd_link_pkg::block_tag_t      block_tag,
    output logic                         byte_load
);

    import sd_link_pkg::*;

    // gap + token + data + two crc bytes, minus one
    localparam byte_off_t last_off =
        byte_off_t'(`SD_GAP_BYTES + 1 + `SD_BLOCK_BYTES + 2 - 1);

    bit_cnt_t bit_cnt;

    assign byte_load = sclk_fall && stream_on && (bit_cnt == 3'd7);

    always_ff @(posedge clk) begin
        if (rst) begin
            stream_on <= 1'b0;
            bit_cnt   <= '0;
            byte_off  <= '0;
            block_tag <= '0;
        end else if (read_start) begin
            stream_on <= 1'b1;
            bit_cnt   <= '0;
            byte_off  <= '0;
            block_tag <= start_tag;
        end else if (read_stop) begin
            stream_on <= 1'b0;
        end else if (stream_on && sclk_fall) begin
            bit_cnt <= bit_cnt + 3'd1;
            if (bit_cnt == 3'd7) begin
                if (byte_off == last_off) begin
                    byte_off  <= '0;
                    block_tag <= block_tag + 8'd1;   // next block, next pattern
                end else begin
                    byte_off <= byte_off + 10'd1;
                end
            end
        end
    end

    a_off_range: assert property (@(posedge clk) disable iff (rst) byte_off <= last_off)
        else $error("byte offset past end of block cycle");

endmodule

`default_nettype wire

//--- sd_read/sd_tx_shifter.sv
`timescale 1ns/1ps
`default_nettype none

`include "sd_defines.svh"

module sd_tx_shifter (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire logic                    sclk_fall,
    input  wire logic                    cs_active,
    input  wire logic                    resp_slot,
    input  wire sd_proto_pkg::resp_t     resp,
    input  wire logic                    stream_on,
    input  wire sd_link_pkg::byte_off_t  byte_off,
    input  wire sd_link_pkg::block_tag_t block_tag,
    input  wire logic                    byte_load,
    output logic                         miso,
    output logic                         miso_en
);

    import sd_proto_pkg::*;
    import sd_link_pkg::*;

    localparam byte_off_t   token_off = byte_off_t'(`SD_GAP_BYTES);
    localparam byte_off_t   crc_off   = byte_off_t'(`SD_GAP_BYTES + 1 + `SD_BLOCK_BYTES);
    localparam logic [15:0] crc_fill  = `SD_CRC_FILL;

    resp_t     tx_sr;       // next bit to send sits in bit 39
    byte_off_t data_off;    // offset inside the 512 data bytes
    logic [7:0] load_byte;

    assign data_off = byte_off - (token_off + byte_off_t'(1));

    always_comb begin
        if (byte_off < token_off) begin
            load_byte = 8'hFF;
        end else if (byte_off == token_off) begin
            load_byte = `SD_DATA_TOKEN;
        end else if (byte_off < crc_off) begin
            load_byte = data_off[7:0] ^ block_tag;
        end else if (byte_off == crc_off) begin
            load_byte = crc_fill[15:8];
        end else begin
            load_byte = crc_fill[7:0];
        end
    end

    // loads put their MSB straight on miso and keep the rest in tx_sr
    always_ff @(posedge clk) begin
        if (rst || !cs_active) begin
            tx_sr <= '1;
            miso  <= 1'b1;
        end else if (resp_slot) begin
            miso  <= resp[39];
            tx_sr <= {resp[38:0], 1'b1};
        end else if (byte_load) begin
            miso  <= load_byte[7];
            tx_sr <= {load_byte[6:0], {33{1'b1}}};
        end else if (sclk_fall) begin
            miso  <= tx_sr[39];
            tx_sr <= {tx_sr[38:0], 1'b1};    // ones behind the data
        end
    end

    assign miso_en = cs_active;

    // a response only ever displaces a filler byte of a running read
    a_resp_in_gap: assert property (@(posedge clk) disable iff (rst)
        resp_slot && stream_on |-> byte_off < token_off)
        else $error("response slot landed on block data");

endmodule

`default_nettype wire

//--- design/sd_spi_card.sv
`timescale 1ns/1ps
`default_nettype none

module sd_spi_card (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 sclk,
    input  wire logic                 cs_n,
    input  wire logic                 mosi,
    output logic                      miso,
    output logic                      miso_en,
    output sd_proto_pkg::card_state_t card_state
);

    import sd_proto_pkg::*;
    import sd_link_pkg::*;

    logic       sclk_rise;
    logic       sclk_fall;
    logic       mosi_bit;
    logic       cs_active;
    logic       cmd_valid;
    logic       resp_slot;
    cmd_idx_t   cmd_idx;
    cmd_arg_t   cmd_arg;
    resp_t      resp;
    logic       read_start;
    logic       read_stop;
    block_tag_t start_tag;
    logic       stream_on;
    logic       byte_load;
    byte_off_t  byte_off;
    block_tag_t block_tag;

    sd_spi_frontend u_frontend (
        .clk(clk), .rst(rst), .sclk(sclk), .cs_n(cs_n), .mosi(mosi),
        .sclk_rise(sclk_rise), .sclk_fall(sclk_fall), .mosi_bit(mosi_bit),
        .cs_active(cs_active)
    );

    sd_cmd_receiver u_receiver (
        .clk(clk), .rst(rst), .sclk_rise(sclk_rise), .sclk_fall(sclk_fall),
        .mosi_bit(mosi_bit), .cs_active(cs_active), .cmd_valid(cmd_valid),
        .cmd_idx(cmd_idx), .cmd_arg(cmd_arg), .resp_slot(resp_slot)
    );

    sd_card_fsm u_fsm (
        .clk(clk), .rst(rst), .cmd_valid(cmd_valid), .cmd_idx(cmd_idx), .cmd_arg(cmd_arg),
        .resp(resp), .card_state(card_state), .read_start(read_start),
        .read_stop(read_stop), .start_tag(start_tag)
    );

    sd_read_counter u_counter (
        .clk(clk), .rst(rst), .sclk_fall(sclk_fall), .read_start(read_start),
        .read_stop(read_stop), .start_tag(start_tag), .stream_on(stream_on),
        .byte_off(byte_off), .block_tag(block_tag), .byte_load(byte_load)
    );

    sd_tx_shifter u_shifter (
        .clk(clk), .rst(rst), .sclk_fall(sclk_fall), .cs_active(cs_active),
        .resp_slot(resp_slot), .resp(resp), .stream_on(stream_on), .byte_off(byte_off),
        .block_tag(block_tag), .byte_load(byte_load), .miso(miso), .miso_en(miso_en)
    );

endmodule

`default_nettype wire

//--- test/sd_spi_card_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "sd_defines.svh"

module sd_spi_card_tb;

    import sd_proto_pkg::*;

    localparam int n_steps   = 12;
    localparam int low_clks  = 6;   // sclk low phase
    localparam int high_clks = 2;   // short high phase, read start settles before the next fall

    logic        clk;
    logic        rst;
    logic        sclk;
    logic        cs_n;
    logic        mosi;
    logic        miso;
    logic        miso_en;
    card_state_t card_state;

    // command table, one row per step
    string       step_name   [n_steps];
    cmd_idx_t    step_idx    [n_steps];
    cmd_arg_t    step_arg    [n_steps];
    r1_t         step_r1     [n_steps];
    int          step_tail_n [n_steps];
    cmd_arg_t    step_tail   [n_steps];
    card_state_t step_state  [n_steps];

    logic [31:0] lfsr;

    sd_spi_card dut (
        .clk(clk), .rst(rst), .sclk(sclk), .cs_n(cs_n), .mosi(mosi),
        .miso(miso), .miso_en(miso_en), .card_state(card_state)
    );

    initial begin
        clk = 1'b0;
    end

    always #50 clk = ~clk;

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_r1(input string name, input r1_t exp, input r1_t act);
        if (act !== exp) begin
            abort_run($sformatf("Error %s: expected %h, got %h", name, exp, act));
        end
    endtask

    task automatic check_word(input string name, input cmd_arg_t exp, input cmd_arg_t act);
        if (act !== exp) begin
            abort_run($sformatf("Error %s: expected %h, got %h", name, exp, act));
        end
    endtask

    task automatic check_state(input string name, input card_state_t exp,
                               input card_state_t act);
        if (act !== exp) begin
            abort_run($sformatf("Error %s: expected %s, got %s", name, exp.name(), act.name()));
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            abort_run($sformatf("Error %s: expected %h, got %h", name, exp, act));
        end
    endtask

    task automatic check_level(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            abort_run($sformatf("Error %s: expected %b, got %b", name, exp, act));
        end
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic step_clk(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    // one byte in mode 0, MSB first
    task automatic spi_byte(input logic [7:0] tx, output logic [7:0] rx);
        int i;
        for (i = 7; i >= 0; i--) begin
            mosi = tx[i];
            step_clk(low_clks);
            sclk = 1'b1;
            step_clk(high_clks);
            rx[i] = miso;       // still the bit put out by the last fall
            sclk = 1'b0;
        end
    endtask

    task automatic wait_select(input logic level);
        int n;
        n = 0;
        while (miso_en !== level && n < 10) begin
            step_clk(1);
            n++;
        end
        if (miso_en !== level) begin
            abort_run("miso_en did not follow cs_n within 10 clk cycles");
        end
    endtask

    task automatic send_command(input cmd_idx_t idx, input cmd_arg_t arg);
        logic [7:0] rx;
        spi_byte({2'b01, idx}, rx);
        spi_byte(arg[31:24], rx);
        spi_byte(arg[23:16], rx);
        spi_byte(arg[15:8], rx);
        spi_byte(arg[7:0], rx);
        spi_byte(8'h01, rx);    // crc7 not checked by the card, end bit set
    endtask

    task automatic wait_r1(input string name, output r1_t r1);
        logic [7:0] rx;
        int         n;
        rx = 8'hFF;
        n  = 0;
        while (rx == 8'hFF && n < 8) begin
            spi_byte(8'hFF, rx);
            n++;
        end
        if (rx == 8'hFF) begin
            abort_run($sformatf("%s: no response within 8 bytes", name));
        end
        r1 = rx;
    endtask

    task automatic wait_token(input string name);
        logic [7:0] rx;
        int         n;
        rx = 8'hFF;
        n  = 0;
        while (rx == 8'hFF && n < 16) begin
            spi_byte(8'hFF, rx);
            n++;
        end
        if (rx == 8'hFF) begin
            abort_run($sformatf("%s: no start token within 16 bytes", name));
        end
        check_byte({name, " token"}, `SD_DATA_TOKEN, rx);
    endtask

    task automatic read_word(input int n, output cmd_arg_t w);
        logic [7:0] rx;
        int         j;
        w = '0;
        for (j = 0; j < n; j++) begin
            spi_byte(8'hFF, rx);
            w = {w[23:0], rx};
        end
    endtask

    task automatic read_block_data(input string name, input logic [7:0] tag, input int count);
        logic [7:0] rx;
        int         i;
        for (i = 0; i < count; i++) begin
            spi_byte(8'hFF, rx);
            check_byte($sformatf("%s byte %0d", name, i), 8'(i) ^ tag, rx);
        end
    endtask

    function automatic void set_row(input int k, input string name, input cmd_idx_t idx,
                                    input cmd_arg_t arg, input r1_t r1, input int tail_n,
                                    input cmd_arg_t tail, input card_state_t state);
        step_name[k]   = name;
        step_idx[k]    = idx;
        step_arg[k]    = arg;
        step_r1[k]     = r1;
        step_tail_n[k] = tail_n;
        step_tail[k]   = tail;
        step_state[k]  = state;
    endfunction

    // R1: bit 0 idle, bit 2 illegal
    task automatic fill_table();
        set_row(0, "cmd8 before cmd0", 6'd8, 32'h0000_01AA, 8'h04, 0, 32'hFFFF_FFFF, st_unknown);
        set_row(1, "cmd0", 6'd0, 32'h0, 8'h01, 0, 32'hFFFF_FFFF, st_idle);
        set_row(2, "cmd8", 6'd8, 32'h0000_01AA, 8'h01, 4, 32'h0000_01AA, st_idle);
        set_row(3, "unsupported cmd5", 6'd5, 32'h0, 8'h05, 0, 32'hFFFF_FFFF, st_idle);
        set_row(4, "acmd41 without cmd55", 6'd41, 32'h4000_0000, 8'h05, 0, 32'hFFFF_FFFF,
                st_idle);
        set_row(5, "cmd55", 6'd55, 32'h0, 8'h01, 0, 32'hFFFF_FFFF, st_idle);
        set_row(6, "acmd41 hcs", 6'd41, 32'h4000_0000, 8'h00, 0, 32'hFFFF_FFFF, st_ready);
        set_row(7, "cmd58", 6'd58, 32'h0, 8'h00, 4, 32'hC0FF_8000, st_ready);
        set_row(8, "cmd0 again", 6'd0, 32'h0, 8'h01, 0, 32'hFFFF_FFFF, st_idle);
        set_row(9, "cmd18 in idle", 6'd18, 32'h0, 8'h05, 0, 32'hFFFF_FFFF, st_idle);
        set_row(10, "cmd55 again", 6'd55, 32'h0, 8'h01, 0, 32'hFFFF_FFFF, st_idle);
        set_row(11, "acmd41 again", 6'd41, 32'h4000_0000, 8'h00, 0, 32'hFFFF_FFFF, st_ready);
    endtask

    task automatic run_step(input int k);
        r1_t      r1;
        cmd_arg_t tail;
        send_command(step_idx[k], step_arg[k]);
        wait_r1(step_name[k], r1);
        check_r1(step_name[k], step_r1[k], r1);
        if (step_tail_n[k] > 0) begin
            read_word(step_tail_n[k], tail);
            check_word(step_name[k], step_tail[k], tail);
        end
        check_state(step_name[k], step_state[k], card_state);
    endtask

    initial begin
        int          k;
        int          i;
        r1_t         r1;
        logic [7:0]  rx;
        logic [7:0]  tag;
        logic [15:0] crc_fill;
        rst      = 1'b1;
        sclk     = 1'b0;
        cs_n     = 1'b1;
        mosi     = 1'b1;
        lfsr     = 32'h930f9d24;
        tag      = 8'h00;
        crc_fill = `SD_CRC_FILL;
        fill_table();

        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        step_clk(2);
        check_level("miso after reset", 1'b1, miso);
        check_level("miso_en with cs_n high", 1'b0, miso_en);
        check_state("after reset", st_unknown, card_state);

        cs_n = 1'b0;
        wait_select(1'b1);

        for (k = 0; k < n_steps; k++) begin
            run_step(k);
        end

        for (i = 0; i < 8; i++) begin
            lfsr = lfsr_step(lfsr);
            tag  = {tag[6:0], lfsr[0]};
        end

        send_command(6'd18, {24'h0, tag});
        wait_r1("cmd18 in ready", r1);
        check_r1("cmd18 in ready", 8'h00, r1);
        check_state("cmd18 in ready", st_data, card_state);

        // first block, gap length unknown after the R1
        wait_token("block0");
        read_block_data("block0", tag, `SD_BLOCK_BYTES);
        spi_byte(8'hFF, rx);
        check_byte("block0 crc high", crc_fill[15:8], rx);
        spi_byte(8'hFF, rx);
        check_byte("block0 crc low", crc_fill[7:0], rx);

        for (i = 0; i < `SD_GAP_BYTES; i++) begin
            spi_byte(8'hFF, rx);
            check_byte($sformatf("block1 gap %0d", i), 8'hFF, rx);
        end
        spi_byte(8'hFF, rx);
        check_byte("block1 token", `SD_DATA_TOKEN, rx);
        read_block_data("block1", tag + 8'd1, 200);

        // stop mid block, the byte after the frame is a stuff byte
        send_command(6'd12, 32'h0);
        spi_byte(8'hFF, rx);
        wait_r1("cmd12", r1);
        check_r1("cmd12", 8'h00, r1);
        check_state("cmd12", st_ready, card_state);
        for (i = 0; i < 6; i++) begin
            spi_byte(8'hFF, rx);
            check_byte($sformatf("idle after cmd12 %0d", i), 8'hFF, rx);
        end

        cs_n = 1'b1;
        wait_select(1'b0);

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
+incdir+common
common/sd_proto_pkg.sv
common/sd_link_pkg.sv
design/sd_spi_frontend.sv
sd_cmd/sd_cmd_receiver.sv
sd_cmd/sd_card_fsm.sv
sd_read/sd_read_counter.sv
sd_read/sd_tx_shifter.sv
design/sd_spi_card.sv
test/sd_spi_card_tb.sv

//--- run.sh
#!/bin/sh
# build and run the SD SPI card testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module sd_spi_card_tb -Mdir obj_dir

./obj_dir/Vsd_spi_card_tb > sim.log 2>&1 || true
cat sim.log

if grep -qF "*** TEST FAILED ***" sim.log; then
    exit 1
fi
exit 0
